//--- dv/core_axi_vectors.txt
# op addr be wdata exp_rdata exp_err, all fields hex except op (R or W)
# be and wdata are unused on reads, exp_rdata is unused on writes
R 00000000 0 00000000 00000000 0
R 000003fc 0 00000000 00000000 0
W 00000010 f deadbeef 00000000 0
R 00000010 0 00000000 deadbeef 0
W 00000020 f 11223344 00000000 0
W 00000020 1 aaaaaa55 00000000 0
R 00000020 0 00000000 11223355 0
W 00000020 c 99887766 00000000 0
R 00000020 0 00000000 99883355 0
W 00000020 6 00abcd00 00000000 0
R 00000020 0 00000000 99abcd55 0
W 00000004 f 0badf00d 00000000 0
R 00000400 0 00000000 00000000 1
W 00000404 f ffffffff 00000000 1
R 00000004 0 00000000 0badf00d 0
W 00000400 f 12345678 00000000 1
R 00000000 0 00000000 00000000 0
R 80000000 0 00000000 00000000 1
W 00000800 3 cafef00d 00000000 1
W 00000100 f 01020304 00000000 0
R 00000100 0 00000000 01020304 0
W 00000104 f a5a5a5a5 00000000 0
W 00000108 f 5a5a5a5a 00000000 0
R 00000104 0 00000000 a5a5a5a5 0
R 00000108 0 00000000 5a5a5a5a 0
W 00000104 8 ff000000 00000000 0
R 00000104 0 00000000 ffa5a5a5 0
W 000003fc f 76543210 00000000 0
R 000003fc 0 00000000 76543210 0
W 00000010 2 0000ee00 00000000 0
R 00000010 0 00000000 deadeeef 0
R 00000020 0 00000000 99abcd55 0
W 00000000 f 13579bdf 00000000 0
R 00000400 0 00000000 00000000 1
R 00000000 0 00000000 13579bdf 0
R 00000004 0 00000000 0badf00d 0

//--- tb.f
+incdir+rtl
rtl/axi_bus_pkg.sv
rtl/axi4_if.sv
rtl/core_axi_master.sv
rtl/axi_sram_slave.sv
rtl/core_axi_subsystem.sv
dv/core_axi_checker.sv
dv/tb_core_axi.sv

//--- run_sim.sh
#!/bin/sh
# Verilator build and run of the core AXI testbench, result taken from sim.log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module tb_core_axi \
	-f tb.f \
	-o sim_core_axi

# the log is kept even when the run ends badly, the search below decides
./obj_dir/sim_core_axi > sim.log 2>&1 || true
cat sim.log

if grep -qx "STATUS: PASS" sim.log; then
	echo "simulation passed"
	exit 0
fi
echo "simulation failed, see sim.log"
exit 1

//--- dv/tb_core_axi.sv
/*
 * testbench top for the core AXI subsystem
 * - clock, reset and vector file reading
 * - falling-edge core requests with random idle gaps
 * - cycle timeout and final status
 */
`timescale 1ns/1ps
`default_nettype none
`include "axi_bus_settings.svh"

module tb_core_axi;

	// cycle budget per access, plus slack for reset and drain
	localparam int ACCESS_CYCLES = 8 + `AXI_READ_WAIT + 3;
	localparam int SLACK_CYCLES  = 20;
	localparam logic [31:0] SEED = 32'h70ba;

	logic                    i_clk;
	logic                    i_rst;
	logic                    i_select;
	logic                    i_write_enable;
	logic [`AXI_DATA_W/8-1:0] i_byte_enable;
	logic [`AXI_ADDR_W-1:0]  i_address;
	logic [`AXI_DATA_W-1:0]  i_write_data;
	logic                    o_stall;
	logic [`AXI_DATA_W-1:0]  o_read_data;
	logic                    o_bus_error;

	// expected result of the access in flight, handed to the checker
	logic [`AXI_DATA_W-1:0]  exp_data;
	logic                    exp_err;
	int                      vec_idx;
	int                      pass_count;
	int                      fail_count;
	int                      done_count;

	// vector table, one entry per file line
	logic                    vec_write [$];
	logic [`AXI_ADDR_W-1:0]  vec_addr [$];
	logic [`AXI_DATA_W/8-1:0] vec_be [$];
	logic [`AXI_DATA_W-1:0]  vec_wdata [$];
	logic [`AXI_DATA_W-1:0]  vec_rdata [$];
	logic                    vec_err [$];

	int                      vec_count;
	int                      load_ok;
	int                      gap;
	int                      cycle_count;
	int                      cycle_limit;

	// ========================================================================
	// DUT and checker
	// ========================================================================
	core_axi_subsystem i_core_axi_subsystem (
		.i_clk          (i_clk),
		.i_rst          (i_rst),
		.i_select       (i_select),
		.i_write_enable (i_write_enable),
		.i_byte_enable  (i_byte_enable),
		.i_address      (i_address),
		.i_write_data   (i_write_data),
		.o_stall        (o_stall),
		.o_read_data    (o_read_data),
		.o_bus_error    (o_bus_error)
	);

	core_axi_checker i_core_axi_checker (
		.i_clk          (i_clk),
		.i_rst          (i_rst),
		.i_select       (i_select),
		.i_write_enable (i_write_enable),
		.i_address      (i_address),
		.i_stall        (o_stall),
		.i_read_data    (o_read_data),
		.i_bus_error    (o_bus_error),
		.i_exp_data     (exp_data),
		.i_exp_err      (exp_err),
		.i_vec_idx      (vec_idx),
		.o_pass_count   (pass_count),
		.o_fail_count   (fail_count),
		.o_done_count   (done_count)
	);

	// 10 ns clock
	always #5 i_clk = ~i_clk;

	// run limit, armed once the vector count is known
	always @(posedge i_clk) begin
		cycle_count <= cycle_count + 1;
		if ((cycle_limit > 0) && (cycle_count >= cycle_limit)) begin
			$display("timeout: the DUT stopped responding within %0d cycles", cycle_limit);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	// ========================================================================
	// tasks
	// ========================================================================
	task automatic drive_idle();
		i_select       = 1'b0;
		i_write_enable = 1'b0;
		i_byte_enable  = '0;
		i_address      = '0;
		i_write_data   = '0;
	endtask

	// skips comment and blank lines, any other line needs all six fields
	task automatic load_vectors(output int count, output int ok);
		int                      fd;
		int                      n;
		string                   line;
		byte                     op;
		logic [`AXI_ADDR_W-1:0]  addr;
		logic [`AXI_DATA_W/8-1:0] be;
		logic [`AXI_DATA_W-1:0]  wdata;
		logic [`AXI_DATA_W-1:0]  rdata;
		logic                    err;
		count = 0;
		ok    = 0;
		fd    = $fopen("dv/core_axi_vectors.txt", "r");
		if (fd != 0) begin
			ok = 1;
			while (!$feof(fd)) begin
				n = $fgets(line, fd);
				if ((n > 0) && (line.len() > 1) && (line[0] != "#")) begin
					n = $sscanf(line, "%c %h %h %h %h %h", op, addr, be, wdata, rdata, err);
					if (n != 6) begin
						$display("bad vector line: %s", line);
						ok = 0;
					end
					vec_write.push_back(op == "W");
					vec_addr.push_back(addr);
					vec_be.push_back(be);
					vec_wdata.push_back(wdata);
					vec_rdata.push_back(rdata);
					vec_err.push_back(err);
					count++;
				end
			end
			$fclose(fd);
		end
	endtask

	// present one held request together with its expected result
	task automatic apply_request(input int v);
		i_select       = 1'b1;
		i_write_enable = vec_write[v];
		i_byte_enable  = vec_be[v];
		i_address      = vec_addr[v];
		i_write_data   = vec_wdata[v];
		exp_data       = vec_rdata[v];
		exp_err        = vec_err[v];
		vec_idx        = v;
	endtask

	// ends on the rising edge where the stall drops
	task automatic wait_complete();
		@(posedge i_clk);
		while (o_stall) begin
			@(posedge i_clk);
		end
	endtask

	// ========================================================================
	// main sequence
	// ========================================================================
	initial begin
		i_clk       = 1'b0;
		i_rst       = 1'b1;
		exp_data    = '0;
		exp_err     = 1'b0;
		vec_idx     = 0;
		cycle_limit = 0;
		drive_idle();
		void'($urandom(SEED));
		load_vectors(vec_count, load_ok);
		if ((load_ok == 0) || (vec_count == 0)) begin
			$display("vector file dv/core_axi_vectors.txt is missing, empty or malformed");
			$display("STATUS: FAIL");
			$finish;
		end else begin
			cycle_limit = vec_count * ACCESS_CYCLES + SLACK_CYCLES;
			repeat (8) @(posedge i_clk);
			@(negedge i_clk);
			i_rst = 1'b0;
			// one idle cycle so the checker sees the port quiet after reset
			@(negedge i_clk);
			for (int v = 0; v < vec_count; v++) begin
				gap = $urandom % 4;
				if (gap > 0) begin
					drive_idle();
					repeat (gap) @(negedge i_clk);
				end
				apply_request(v);
				wait_complete();
				@(negedge i_clk);
			end
			drive_idle();
			repeat (2) @(negedge i_clk);
			$display("results: %0d passed, %0d failed, %0d of %0d accesses completed",
				pass_count, fail_count, done_count, vec_count);
			if ((fail_count == 0) && (done_count == vec_count)) begin
				$display("STATUS: PASS");
			end else begin
				$display("STATUS: FAIL");
			end
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- dv/core_axi_checker.sv
/*
 * result checker for the core AXI subsystem
 * - read data and error flag compared at each completed access
 * - stall and error checked while the core port is idle
 * - pass, fail and completion counters
 */
`timescale 1ns/1ps
`default_nettype none
`include "axi_bus_settings.svh"

module core_axi_checker (
	input  wire                      i_clk,
	input  wire                      i_rst,

	// core port as seen at the DUT
	input  wire                      i_select,
	input  wire                      i_write_enable,
	input  wire  [`AXI_ADDR_W-1:0]   i_address,
	input  wire                      i_stall,
	input  wire  [`AXI_DATA_W-1:0]   i_read_data,
	input  wire                      i_bus_error,

	// expected result of the access in flight
	input  wire  [`AXI_DATA_W-1:0]   i_exp_data,
	input  wire                      i_exp_err,
	input  wire  [31:0]              i_vec_idx,

	output int                       o_pass_count,
	output int                       o_fail_count,
	output int                       o_done_count
);

	logic ok;

	// ========================================================================
	// compare on the completing edge, select high and stall low
	// ========================================================================
	always @(posedge i_clk) begin
		if (i_rst) begin
			o_pass_count <= 0;
			o_fail_count <= 0;
			o_done_count <= 0;
		end else if (i_select && !i_stall) begin
			ok = 1'b1;
			// read data only matters on reads
			if (!i_write_enable && (i_read_data !== i_exp_data)) begin
				$display("Mismatch at %0t: vector %0d read %h from %h, expected %h",
					$time, i_vec_idx, i_read_data, i_address, i_exp_data);
				ok = 1'b0;
			end
			if (i_bus_error !== i_exp_err) begin
				$display("Mismatch at %0t: vector %0d bus error %b at %h, expected %b",
					$time, i_vec_idx, i_bus_error, i_address, i_exp_err);
				ok = 1'b0;
			end
			o_done_count <= o_done_count + 1;
			if (ok) begin
				o_pass_count <= o_pass_count + 1;
			end else begin
				o_fail_count <= o_fail_count + 1;
			end
			$display("vector %0d %s %h: %s", i_vec_idx, i_write_enable ? "W" : "R",
				i_address, ok ? "ok" : "wrong");
		end else if ((i_bus_error !== 1'b0) || (!i_select && (i_stall !== 1'b0))) begin
			// error pulse only on completion, no stall without a request
			$display("Mismatch at %0t: stall %b error %b outside a completing access",
				$time, i_stall, i_bus_error);
			o_fail_count <= o_fail_count + 1;
		end
	end

endmodule

`default_nettype wire

//--- rtl/core_axi_subsystem.sv
/*
 * top level: core data port, AXI4 master and on-chip RAM slave
 * joined through one AXI4 bundle
 */
`timescale 1ns/1ps
`default_nettype none
`include "axi_bus_settings.svh"

module core_axi_subsystem (
	input  wire                         i_clk,
	input  wire                         i_rst,

	// core data-memory port
	input  wire                         i_select,
	input  wire                         i_write_enable,
	input  wire  [`AXI_DATA_W/8-1:0]    i_byte_enable,
	input  wire  [`AXI_ADDR_W-1:0]      i_address,
	input  wire  [`AXI_DATA_W-1:0]      i_write_data,
	output logic                        o_stall,
	output logic [`AXI_DATA_W-1:0]      o_read_data,
	output logic                        o_bus_error
);

	// ========================================================================
	// internal bus
	// ========================================================================
	axi4_if bus ();

	// bridge from the core port, one transaction per held request
	core_axi_master i_core_axi_master (
		.i_clk          (i_clk),
		.i_rst          (i_rst),
		.i_select       (i_select),
		.i_write_enable (i_write_enable),
		.i_byte_enable  (i_byte_enable),
		.i_address      (i_address),
		.i_write_data   (i_write_data),
		.o_stall        (o_stall),
		.o_read_data    (o_read_data),
		.o_bus_error    (o_bus_error),
		.bus            (bus.master)
	);

	// ram answers every beat, errors above the top word
	axi_sram_slave i_axi_sram_slave (
		.i_clk (i_clk),
		.i_rst (i_rst),
		.bus   (bus.slave)
	);

endmodule

`default_nettype wire

//--- rtl/axi_sram_slave.sv
/*
 * AXI4 single-beat RAM slave
 * - byte-strobe writes and a fixed read wait counter
 * - SLVERR and zero data for out-of-range word addresses
 */
`timescale 1ns/1ps
`default_nettype none
`include "axi_bus_settings.svh"

module axi_sram_slave (
	input  wire         i_clk,
	input  wire         i_rst,
	axi4_if.slave       bus
);

	localparam int IDX_W = $clog2(`AXI_MEM_WORDS);
	localparam int CNT_W = $clog2(`AXI_READ_WAIT + 1);
	localparam logic [CNT_W-1:0] WAIT_LOAD = CNT_W'(`AXI_READ_WAIT - 1);
	localparam logic [`AXI_ADDR_W-3:0] WORD_LIMIT = (`AXI_ADDR_W - 2)'(`AXI_MEM_WORDS);
	localparam logic [2:0] BEAT_SIZE = 3'($clog2(`AXI_DATA_W / 8));

	logic [`AXI_DATA_W-1:0]  mem [`AXI_MEM_WORDS];

	axi_bus_pkg::slv_state_e state;
	axi_bus_pkg::axi_resp_e  resp;
	logic [CNT_W-1:0]        wait_cnt;
	logic                    w_ready_q;
	logic                    b_valid_q;
	logic [`AXI_ADDR_W-1:0]  addr_q;
	logic [`AXI_DATA_W-1:0]  rdata_q;
	logic [IDX_W-1:0]        word_idx;
	logic                    addr_err;
	logic                    ar_fire;
	logic                    aw_fire;
	logic                    w_fire;
	logic                    r_fire;
	logic                    b_fire;
	logic                    wait_done;

	// ram starts cleared
	initial begin
		for (int i = 0; i < `AXI_MEM_WORDS; i++) begin
			mem[i] = '0;
		end
	end

	// address only taken in idle and AR wins a tie
	assign bus.ARREADY = (state == axi_bus_pkg::S_IDLE);
	assign bus.AWREADY = (state == axi_bus_pkg::S_IDLE) && !bus.ARVALID;

	assign ar_fire   = bus.ARVALID && bus.ARREADY;
	assign aw_fire   = bus.AWVALID && bus.AWREADY;
	assign w_fire    = bus.WVALID && bus.WREADY;
	assign r_fire    = bus.RVALID && bus.RREADY;
	assign b_fire    = bus.BVALID && bus.BREADY;
	assign wait_done = (state == axi_bus_pkg::S_READ_WAIT) && (wait_cnt == '0);

	// word decode from bits 31:2 of the latched address
	assign addr_err = (addr_q[`AXI_ADDR_W-1:2] >= WORD_LIMIT);
	assign word_idx = addr_q[IDX_W+1:2];
	assign resp     = addr_err ? axi_bus_pkg::SLVERR : axi_bus_pkg::OKAY;

	// ========================================================================
	// control FSM
	// ========================================================================
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			state     <= axi_bus_pkg::S_IDLE;
			wait_cnt  <= '0;
			w_ready_q <= 1'b0;
			b_valid_q <= 1'b0;
		end else begin
			case (state)
				axi_bus_pkg::S_IDLE: begin
					if (ar_fire) begin
						wait_cnt <= WAIT_LOAD;
						state    <= axi_bus_pkg::S_READ_WAIT;
					end else if (aw_fire) begin
						w_ready_q <= 1'b1;
						state     <= axi_bus_pkg::S_WRITE_RESP;
					end
				end
				axi_bus_pkg::S_READ_WAIT: begin
					if (wait_done) begin
						state <= axi_bus_pkg::S_READ_RESP;
					end else begin
						wait_cnt <= wait_cnt - 1'b1;
					end
				end
				axi_bus_pkg::S_READ_RESP: begin
					if (r_fire) begin
						state <= axi_bus_pkg::S_IDLE;
					end
				end
				axi_bus_pkg::S_WRITE_RESP: begin
					// W beat first and the response goes out the cycle after
					if (w_fire) begin
						w_ready_q <= 1'b0;
						b_valid_q <= 1'b1;
					end
					if (b_fire) begin
						b_valid_q <= 1'b0;
						state     <= axi_bus_pkg::S_IDLE;
					end
				end
				default: state <= axi_bus_pkg::S_IDLE;
			endcase
		end
	end

	// latched address and read word
	always_ff @(posedge i_clk) begin
		if (ar_fire) begin
			addr_q <= bus.ARADDR;
		end else if (aw_fire) begin
			addr_q <= bus.AWADDR;
		end
		if (wait_done) begin
			rdata_q <= addr_err ? '0 : mem[word_idx];
		end
	end

	// byte merge that leaves the ram untouched on an out-of-range write
	always_ff @(posedge i_clk) begin
		if (w_fire && !addr_err) begin
			for (int b = 0; b < `AXI_DATA_W / 8; b++) begin
				if (bus.WSTRB[b]) begin
					mem[word_idx][8*b +: 8] <= bus.WDATA[8*b +: 8];
				end
			end
		end
	end

	assign bus.RVALID = (state == axi_bus_pkg::S_READ_RESP);
	assign bus.RDATA  = rdata_q;
	assign bus.RRESP  = resp;
	assign bus.RLAST  = bus.RVALID;
	assign bus.WREADY = w_ready_q;
	assign bus.BVALID = b_valid_q;
	assign bus.BRESP  = resp;

	// ========================================================================
	// assertions
	// ========================================================================
	r_stable: assert property (@(posedge i_clk) disable iff (i_rst)
		bus.RVALID && !bus.RREADY |=> bus.RVALID && $stable(bus.RDATA));

	b_stable: assert property (@(posedge i_clk) disable iff (i_rst)
		bus.BVALID && !bus.BREADY |=> bus.BVALID && $stable(bus.BRESP));

	// only single full-width beats with WLAST set are supported
	one_beat: assert property (@(posedge i_clk) disable iff (i_rst)
		(!bus.ARVALID || (bus.ARLEN == 8'd0 && bus.ARSIZE == BEAT_SIZE)) &&
		(!bus.AWVALID || (bus.AWLEN == 8'd0 && bus.AWSIZE == BEAT_SIZE)) &&
		(!bus.WVALID || bus.WLAST));

endmodule

`default_nettype wire

//--- rtl/core_axi_master.sv
/*
 * core data port to AXI4 master
 * - read and write FSMs issuing one single-beat transaction per core access
 * - stall, read data and error pulse back to the core
 * - handshake checks on AR, AW and R
 */
`timescale 1ns/1ps
`default_nettype none
`include "axi_bus_settings.svh"

module core_axi_master (
	input  wire                         i_clk,
	input  wire                         i_rst,

	// core request held while o_stall is high
	input  wire                         i_select,
	input  wire                         i_write_enable,
	input  wire  [`AXI_DATA_W/8-1:0]    i_byte_enable,
	input  wire  [`AXI_ADDR_W-1:0]      i_address,
	input  wire  [`AXI_DATA_W-1:0]      i_write_data,
	output logic                        o_stall,
	output logic [`AXI_DATA_W-1:0]      o_read_data,
	output logic                        o_bus_error,

	axi4_if.master                      bus
);

	// log2 of the bytes per beat (2 for a 32-bit bus)
	localparam logic [2:0] BEAT_SIZE = 3'($clog2(`AXI_DATA_W / 8));

	logic                    read_req;
	logic                    write_req;
	logic                    rd_done;
	logic                    wr_done;
	axi_bus_pkg::rd_state_e  rd_state;
	axi_bus_pkg::wr_state_e  wr_state;

	assign read_req  = i_select & ~i_write_enable;
	assign write_req = i_select & i_write_enable;

	// completing handshake is R for reads and B for writes
	assign rd_done = (rd_state == axi_bus_pkg::RD_DATA) && bus.RVALID && bus.RREADY;
	assign wr_done = (wr_state == axi_bus_pkg::WR_RESP) && bus.BVALID && bus.BREADY;

	// ========================================================================
	// read FSM
	// ========================================================================
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			rd_state <= axi_bus_pkg::RD_IDLE;
		end else begin
			case (rd_state)
				axi_bus_pkg::RD_IDLE: begin
					if (read_req) begin
						rd_state <= axi_bus_pkg::RD_ADDR;
					end
				end
				axi_bus_pkg::RD_ADDR: begin
					// address accepted so wait for the single R beat
					if (bus.ARVALID && bus.ARREADY) begin
						rd_state <= axi_bus_pkg::RD_DATA;
					end
				end
				axi_bus_pkg::RD_DATA: begin
					if (rd_done) begin
						rd_state <= axi_bus_pkg::RD_IDLE;
					end
				end
				default: rd_state <= axi_bus_pkg::RD_IDLE;
			endcase
		end
	end

	// ========================================================================
	// write FSM
	// ========================================================================
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			wr_state <= axi_bus_pkg::WR_IDLE;
		end else begin
			case (wr_state)
				axi_bus_pkg::WR_IDLE: begin
					if (write_req) begin
						wr_state <= axi_bus_pkg::WR_ADDR;
					end
				end
				axi_bus_pkg::WR_ADDR: begin
					if (bus.AWVALID && bus.AWREADY) begin
						wr_state <= axi_bus_pkg::WR_DATA;
					end
				end
				axi_bus_pkg::WR_DATA: begin
					// the single beat is also the last one
					if (bus.WVALID && bus.WREADY) begin
						wr_state <= axi_bus_pkg::WR_RESP;
					end
				end
				axi_bus_pkg::WR_RESP: begin
					if (wr_done) begin
						wr_state <= axi_bus_pkg::WR_IDLE;
					end
				end
				default: wr_state <= axi_bus_pkg::WR_IDLE;
			endcase
		end
	end

	// address and data come straight from the held core request
	assign bus.ARVALID = (rd_state == axi_bus_pkg::RD_ADDR);
	assign bus.ARADDR  = i_address;
	assign bus.ARLEN   = 8'd0;
	assign bus.ARSIZE  = BEAT_SIZE;
	assign bus.RREADY  = 1'b1;

	assign bus.AWVALID = (wr_state == axi_bus_pkg::WR_ADDR);
	assign bus.AWADDR  = i_address;
	assign bus.AWLEN   = 8'd0;
	assign bus.AWSIZE  = BEAT_SIZE;

	assign bus.WVALID  = (wr_state == axi_bus_pkg::WR_DATA);
	assign bus.WDATA   = i_write_data;
	assign bus.WSTRB   = i_byte_enable;
	assign bus.WLAST   = bus.WVALID;
	assign bus.BREADY  = (wr_state == axi_bus_pkg::WR_RESP);

	// core sees a stall until the completing beat and a one-cycle error pulse
	assign o_stall     = (read_req && !rd_done) || (write_req && !wr_done);
	assign o_read_data = bus.RDATA;
	assign o_bus_error = (rd_done && (bus.RRESP == axi_bus_pkg::SLVERR)) ||
	                     (wr_done && (bus.BRESP == axi_bus_pkg::SLVERR));

	// ========================================================================
	// assertions
	// ========================================================================
	// AR stays up with a stable address until the slave takes it
	ar_hold: assert property (@(posedge i_clk) disable iff (i_rst)
		bus.ARVALID && !bus.ARREADY |=> bus.ARVALID && $stable(bus.ARADDR));

	// AW holds the same way and relies on the core keeping its request
	aw_hold: assert property (@(posedge i_clk) disable iff (i_rst)
		bus.AWVALID && !bus.AWREADY |=> bus.AWVALID && $stable(bus.AWADDR));

	// an R beat only comes back for the one outstanding read and is its last
	rd_one: assert property (@(posedge i_clk) disable iff (i_rst)
		bus.RVALID |-> (rd_state == axi_bus_pkg::RD_DATA) && bus.RLAST);

endmodule

`default_nettype wire

//--- rtl/axi4_if.sv
/*
 * AXI4 bundle of the five channels, single-beat subset
 * - master modport for the core bridge
 * - slave modport for the RAM
 */
`timescale 1ns/1ps
`default_nettype none
`include "axi_bus_settings.svh"

interface axi4_if;

	// read address channel
	logic                        ARVALID;
	logic                        ARREADY;
	logic [`AXI_ADDR_W-1:0]      ARADDR;
	logic [7:0]                  ARLEN;
	logic [2:0]                  ARSIZE;

	// read data channel
	logic                        RVALID;
	logic                        RREADY;
	logic [`AXI_DATA_W-1:0]      RDATA;
	axi_bus_pkg::axi_resp_e      RRESP;
	logic                        RLAST;

	// write address channel
	logic                        AWVALID;
	logic                        AWREADY;
	logic [`AXI_ADDR_W-1:0]      AWADDR;
	logic [7:0]                  AWLEN;
	logic [2:0]                  AWSIZE;

	// write data channel
	logic                        WVALID;
	logic                        WREADY;
	logic [`AXI_DATA_W-1:0]      WDATA;
	logic [`AXI_DATA_W/8-1:0]    WSTRB;
	logic                        WLAST;

	// write response channel
	logic                        BVALID;
	logic                        BREADY;
	axi_bus_pkg::axi_resp_e      BRESP;

	modport master (
		output ARVALID, ARADDR, ARLEN, ARSIZE, RREADY,
		output AWVALID, AWADDR, AWLEN, AWSIZE,
		output WVALID, WDATA, WSTRB, WLAST, BREADY,
		input  ARREADY, RVALID, RDATA, RRESP, RLAST,
		input  AWREADY, WREADY, BVALID, BRESP
	);

	modport slave (
		input  ARVALID, ARADDR, ARLEN, ARSIZE, RREADY,
		input  AWVALID, AWADDR, AWLEN, AWSIZE,
		input  WVALID, WDATA, WSTRB, WLAST, BREADY,
		output ARREADY, RVALID, RDATA, RRESP, RLAST,
		output AWREADY, WREADY, BVALID, BRESP
	);

endinterface

`default_nettype wire

//--- rtl/axi_bus_pkg.sv
/*
 * shared AXI types for the core data-port bridge
 * - response codes
 * - master read and write FSM states
 * - memory slave FSM states
 */
`default_nettype none

package axi_bus_pkg;

	// only OKAY and SLVERR are ever produced by the RAM slave
	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		SLVERR = 2'b10
	} axi_resp_e;

	// master read side, one AR then one R beat
	typedef enum logic [1:0] {
		RD_IDLE = 2'd0,
		RD_ADDR = 2'd1,
		RD_DATA = 2'd2
	} rd_state_e;

	// master write side, AW then W then B
	typedef enum logic [1:0] {
		WR_IDLE = 2'd0,
		WR_ADDR = 2'd1,
		WR_DATA = 2'd2,
		WR_RESP = 2'd3
	} wr_state_e;

	// slave FSM, write data and write response share S_WRITE_RESP
	typedef enum logic [1:0] {
		S_IDLE       = 2'd0,
		S_READ_WAIT  = 2'd1,
		S_READ_RESP  = 2'd2,
		S_WRITE_RESP = 2'd3
	} slv_state_e;

endpackage

`default_nettype wire

//--- rtl/axi_bus_settings.svh
/*
 * bus widths, RAM depth and slave read latency
 */
`ifndef AXI_BUS_SETTINGS_SVH
`define AXI_BUS_SETTINGS_SVH

// address and data widths, strobe is AXI_DATA_W/8 wide
`define AXI_ADDR_W 32
`define AXI_DATA_W 32

// ram depth in 32-bit words, word addresses at or above this are out of range
`define AXI_MEM_WORDS 256

// cycles the slave spends between AR accept and RVALID, keep at 1 or more
`define AXI_READ_WAIT 2

`endif
